//--- design/string_pkg.sv
package string_pkg;

	localparam int num_voices = 12; // one string per pitch class
	localparam int sample_width = 16;
	localparam int mix_width = 24;
	localparam int delay_width = 10;
	localparam int octave_top = 9; // string advances every cycle from here up
	localparam int half_note_first = 120; // notes from here on use half length

	// delay length per pitch class, C first
	localparam logic [delay_width-1:0] base_delay [num_voices] = '{
		10'd734, 10'd693, 10'd654, 10'd617,
		10'd582, 10'd550, 10'd519, 10'd490,
		10'd462, 10'd436, 10'd412, 10'd389
	};

	localparam logic [6:0] seg_blank = 7'b1111111;
	localparam logic [6:0] seg_flat = 7'b1111100; // b

	localparam logic [6:0] letter_seg [num_voices] = '{
		7'b0111001, 7'b1011110, 7'b1011110, 7'b1111001, // c d d e
		7'b1111001, 7'b1110001, 7'b1111101, 7'b1111101, // e f g g
		7'b1110111, 7'b1110111, 7'b1111100, 7'b1111100 // a a b b
	};

	localparam logic [6:0] flat_seg [num_voices] = '{
		seg_blank, seg_flat, seg_blank, seg_flat,
		seg_blank, seg_blank, seg_flat, seg_blank,
		seg_flat, seg_blank, seg_flat, seg_blank
	};

	// command to one string, strike and damp are single-cycle pulses
	typedef struct packed {
		logic strike;
		logic damp;
		logic [3:0] octave;
		logic half_length;
		logic [6:0] velocity;
	} voice_cmd_t;

endpackage

//--- design/note_decoder.sv
module note_decoder import string_pkg::*; (
	input logic a_clk,
	input logic reset_n,
	input logic [6:0] note_number,
	input logic [6:0] velocity,
	input logic note_on,
	input logic note_off,
	output voice_cmd_t cmd [num_voices],
	output logic [6:0] hex0,
	output logic [6:0] hex1
);

	logic [6:0] remainder;
	logic [3:0] pitch_class;
	logic [3:0] note_octave;
	logic half_length;

	// note number into pitch class and octave
	always_comb
	begin
		remainder = note_number;
		note_octave = '0;
		for (int i = 0; i < 10; i++)
		begin
			if (remainder >= 7'd12)
			begin
				remainder = remainder - 7'd12; // one octave off
				note_octave = note_octave + 4'd1;
			end
		end
		pitch_class = remainder[3:0]; // always below 12 here
	end

	assign half_length = (note_number >= 7'(half_note_first));

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			for (int i = 0; i < num_voices; i++)
			begin
				cmd[i] <= '0;
			end
			hex0 <= seg_blank;
			hex1 <= seg_blank;
		end
		else
		begin
			for (int i = 0; i < num_voices; i++)
			begin
				cmd[i].strike <= 1'b0; // pulses last one cycle
				cmd[i].damp <= 1'b0;
			end
			if (note_on) // note_on wins over note_off
			begin
				cmd[pitch_class] <= '{
					strike: 1'b1,
					damp: 1'b0,
					octave: note_octave,
					half_length: half_length,
					velocity: velocity
				};
				hex0 <= letter_seg[pitch_class];
				hex1 <= flat_seg[pitch_class];
			end
			else if (note_off)
			begin
				cmd[pitch_class].damp <= 1'b1; // displays keep last note
			end
		end
	end

endmodule

//--- design/noise_bank.sv
module noise_bank import string_pkg::*; (
	input logic a_clk,
	input logic reset_n,
	output logic signed [sample_width-1:0] noise [num_voices]
);

	localparam logic [23:0] lfsr_seed = 24'h5a3c71;

	logic [23:0] lfsr;
	logic feedback;
	logic [47:0] lfsr_twice;

	// taps 24 23 22 17, maximal length
	assign feedback = lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16];

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			lfsr <= lfsr_seed;
		end
		else
		begin
			lfsr <= {lfsr[22:0], feedback};
		end
	end

	assign lfsr_twice = {lfsr, lfsr}; // wraps for the rotated slices

	// each string gets its own rotation, seven bits apart
	for (genvar i = 0; i < num_voices; i++)
	begin : g_slice
		localparam int offset = (i * 7) % 24;

		assign noise[i] = lfsr_twice[offset +: sample_width];
	end

endmodule

//--- design/string_voice.sv
module string_voice import string_pkg::*; (
	input logic a_clk,
	input logic reset_n,
	input voice_cmd_t cmd,
	input logic signed [sample_width-1:0] noise,
	input logic [delay_width-1:0] delay_len,
	output logic signed [sample_width-1:0] sample
);

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_ring
	} voice_state_t;

	voice_state_t state;
	logic [delay_width-1:0] ptr;
	logic [delay_width-1:0] len_q;
	logic [3:0] octave_q;
	logic [6:0] vel_q;
	logic [8:0] div_cnt;
	logic [3:0] div_shift;
	logic [8:0] div_mask;
	logic tick;
	logic advance;
	logic signed [sample_width-1:0] mem [2**delay_width];
	logic signed [sample_width-1:0] tap;
	logic signed [sample_width-1:0] prev_tap;
	logic signed [sample_width+6:0] product;
	logic signed [sample_width-1:0] fill_word;
	logic signed [sample_width:0] pair_sum;
	logic signed [sample_width-1:0] next_word;

	// octave divider, 2^(octave_top - octave) cycles per tick
	assign div_shift = 4'(octave_top - int'(octave_q));
	assign div_mask = ~(9'h1ff << div_shift);
	assign tick = (octave_q >= 4'(octave_top)) || ((div_cnt & div_mask) == 9'd0);

	// a strike or damp this cycle overrides the step
	assign advance = tick && (state != st_idle) && !cmd.strike && !cmd.damp;

	assign tap = mem[ptr];
	assign product = noise * $signed({1'b0, vel_q}); // fits in 23 bits
	assign fill_word = product[sample_width+6:7]; // top 16 bits
	assign pair_sum = tap + prev_tap;
	assign next_word = (state == st_fill) ? fill_word : pair_sum[sample_width:1];

	always_comb
	begin
		case (state)
			st_fill: sample = fill_word;
			st_ring: sample = tap;
			default: sample = '0;
		endcase
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state <= st_idle;
			ptr <= '0;
			div_cnt <= '0;
		end
		else
		begin
			div_cnt <= div_cnt + 9'd1; // free running
			if (cmd.strike)
			begin
				state <= st_fill;
				ptr <= '0;
			end
			else if (cmd.damp)
			begin
				state <= st_idle;
			end
			else if (advance)
			begin
				if (ptr == len_q - 10'd1)
				begin
					ptr <= '0;
					if (state == st_fill)
					begin
						state <= st_ring; // line is full
					end
				end
				else
				begin
					ptr <= ptr + 10'd1;
				end
			end
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (cmd.strike)
		begin
			octave_q <= cmd.octave;
			vel_q <= cmd.velocity;
			len_q <= cmd.half_length ? (delay_len >> 1) : delay_len;
		end
		if (advance)
		begin
			mem[ptr] <= next_word;
			prev_tap <= (state == st_fill) ? fill_word : tap; // neighbour for next mean
		end
	end

endmodule

//--- design/string_bank.sv
module string_bank import string_pkg::*; (
	input logic a_clk,
	input logic reset_n,
	input voice_cmd_t cmd [num_voices],
	input logic signed [sample_width-1:0] noise [num_voices],
	output logic signed [mix_width-1:0] string_mix
);

	logic signed [sample_width-1:0] sample [num_voices];
	logic signed [mix_width-1:0] mix_sum;

	for (genvar i = 0; i < num_voices; i++)
	begin : g_voice
		string_voice u_voice (
			.a_clk(a_clk),
			.reset_n(reset_n),
			.cmd(cmd[i]),
			.noise(noise[i]),
			.delay_len(base_delay[i]),
			.sample(sample[i])
		);
	end

	// twelve 16-bit words cannot overflow 24 bits
	always_comb
	begin
		mix_sum = '0;
		for (int i = 0; i < num_voices; i++)
		begin
			mix_sum = mix_sum + mix_width'(sample[i]); // sign extended
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			string_mix <= '0;
		end
		else
		begin
			string_mix <= mix_sum;
		end
	end

endmodule

//--- design/string_synth_top.sv
module string_synth_top import string_pkg::*; (
	input logic a_clk,
	input logic reset_n,
	input logic [6:0] note_number,
	input logic [6:0] velocity,
	input logic note_on,
	input logic note_off,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic signed [mix_width-1:0] string_mix
);

	voice_cmd_t cmd [num_voices];
	logic signed [sample_width-1:0] noise [num_voices];

	note_decoder u_decoder (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.note_number(note_number),
		.velocity(velocity),
		.note_on(note_on),
		.note_off(note_off),
		.cmd(cmd),
		.hex0(hex0),
		.hex1(hex1)
	);

	noise_bank u_noise (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.noise(noise)
	);

	// twelve strings and the mix register
	string_bank u_strings (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.cmd(cmd),
		.noise(noise),
		.string_mix(string_mix)
	);

endmodule

//--- bench/tb_string_synth.sv
module tb_string_synth import string_pkg::*; ();

	localparam int clk_period = 40;
	localparam int slow_tick = 512; // octave 0 divider period
	localparam int slow_fill_cycles = 734 * slow_tick; // octave 0 C string, the longest fill
	localparam int test_cycles = slow_fill_cycles + 8000; // all six tests together
	localparam int watchdog_cycles = test_cycles + 2000;

	logic a_clk = 1'b0;
	logic reset_n;
	logic [6:0] note_number;
	logic [6:0] velocity;
	logic note_on;
	logic note_off;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic signed [mix_width-1:0] string_mix;

	int seed = 17113;
	int errors = 0;
	int err_mark = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic blank_check = 1'b1; // displays blank until the first note_on
	logic expect_zero = 1'b1;
	int mix_limit = -1; // magnitude bound, off when negative
	int mag;

	string_synth_top uut (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.note_number(note_number),
		.velocity(velocity),
		.note_on(note_on),
		.note_off(note_off),
		.hex0(hex0),
		.hex1(hex1),
		.string_mix(string_mix)
	);

	always #20 a_clk = ~a_clk;

	task automatic value_error(input string name, input int expected, input int actual);
		$display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
		errors++;
	endtask

	task automatic finish_test(input string name);
		if (errors > err_mark)
		begin
			$display("test %s: failed with %0d errors", name, errors - err_mark);
			tests_failed++;
		end
		else
		begin
			$display("test %s: ok", name);
			tests_passed++;
		end
		err_mark = errors;
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge a_clk)
	begin
		mag = int'(string_mix);
		if (mag < 0)
		begin
			mag = -mag;
		end
		if (blank_check)
		begin
			assert (hex0 == seg_blank) else value_error("hex0", int'(seg_blank), int'(hex0));
			assert (hex1 == seg_blank) else value_error("hex1", int'(seg_blank), int'(hex1));
		end
		if (expect_zero)
		begin
			assert (string_mix == '0) else value_error("string_mix", 0, int'(string_mix));
		end
		if (mix_limit >= 0)
		begin
			assert (mag <= mix_limit)
			else
			begin
				$display("FAIL t=%0t string_mix expected magnitude at most %0d actual %0d",
					$time, mix_limit, int'(string_mix));
				errors++;
			end
		end
	end

	// fill length in cycles, top notes run at full rate on half the table
	function automatic int fill_cycles(input int note);
		logic [3:0] pc;
		int len;
		pc = 4'(note % 12);
		len = int'(base_delay[pc]);
		if (note >= 120)
		begin
			len = len / 2;
		end
		return len;
	endfunction

	task automatic strike_note(input int note, input int vel);
		@(posedge a_clk);
		note_number <= 7'(note);
		velocity <= 7'(vel);
		note_on <= 1'b1;
		@(posedge a_clk);
		note_on <= 1'b0; // decoder has taken it at this edge
	endtask

	task automatic release_note(input int note);
		@(posedge a_clk);
		note_number <= 7'(note);
		note_off <= 1'b1;
		@(posedge a_clk);
		note_off <= 1'b0;
	endtask

	task automatic check_display(input int note);
		logic [3:0] pc;
		pc = 4'(note % 12);
		@(negedge a_clk);
		assert (hex0 == letter_seg[pc]) else value_error("hex0", int'(letter_seg[pc]), int'(hex0));
		assert (hex1 == flat_seg[pc]) else value_error("hex1", int'(flat_seg[pc]), int'(hex1));
	endtask

	task automatic wait_sounding(input int window);
		int n;
		n = 0;
		while (string_mix == '0 && n < window)
		begin
			@(negedge a_clk);
			n++;
		end
		assert (string_mix != '0)
		else
		begin
			$display("string_mix stayed zero for %0d cycles after a note_on", window);
			errors++;
		end
	endtask

	// mix must be zero two cycles after the decoder takes note_off
	task automatic damp_and_check(input int note);
		release_note(note);
		@(posedge a_clk);
		@(posedge a_clk);
		expect_zero = 1'b1;
		mix_limit = -1;
		repeat (50) @(negedge a_clk);
	endtask

	initial
	begin
		int r;
		int note;
		int vel;
		int note_b;
		int vel_b;
		int nonzero;
		reset_n = 1'b1;
		note_number = '0;
		velocity = '0;
		note_on = 1'b0;
		note_off = 1'b0;
		repeat (2) @(posedge a_clk);
		reset_n <= 1'b0;
		repeat (6) @(negedge a_clk);
		finish_test("reset state");

		blank_check = 1'b0;
		expect_zero = 1'b0;
		for (int i = 0; i < 24; i++)
		begin
			r = $random(seed);
			note = r & 127;
			vel = (r >> 7) & 127;
			strike_note(note, vel);
			check_display(note);
			r = $random(seed);
			release_note(r & 127);
			check_display(note); // note_off keeps the last letter
		end
		for (int pc = 0; pc < num_voices; pc++)
		begin
			release_note(pc);
		end
		@(posedge a_clk);
		@(posedge a_clk);
		expect_zero = 1'b1;
		repeat (4) @(negedge a_clk);
		finish_test("display decode");

		strike_note(0, 0);
		repeat (slow_fill_cycles + slow_tick + 3) @(negedge a_clk); // first tick may lag a period
		release_note(0);
		repeat (2) @(posedge a_clk);
		finish_test("silence at zero velocity");

		r = $random(seed);
		note = 120 + (r & 7);
		vel = 16 + ((r >> 3) & 63);
		expect_zero = 1'b0;
		mix_limit = 256 * vel; // 32768 * vel / 128
		strike_note(note, vel);
		wait_sounding(fill_cycles(note) + 3);
		repeat (3 * fill_cycles(note)) @(negedge a_clk);
		finish_test("sounding and bound");

		damp_and_check(note);
		finish_test("damping");

		r = $random(seed);
		note = 120 + (r & 7);
		note_b = 120 + (((r & 7) + 1 + (((r >> 3) & 255) % 7)) % 8); // other pitch class
		vel = 16 + ((r >> 11) & 63);
		vel_b = 16 + ((r >> 17) & 63);
		expect_zero = 1'b0;
		mix_limit = 256 * (vel + vel_b);
		strike_note(note, vel);
		strike_note(note_b, vel_b);
		repeat (400) @(negedge a_clk); // both lines full by now
		release_note(note);
		@(posedge a_clk);
		@(posedge a_clk);
		mix_limit = 256 * vel_b;
		nonzero = 0;
		repeat (200)
		begin
			@(negedge a_clk);
			if (string_mix != '0)
			begin
				nonzero++;
			end
		end
		assert (nonzero > 0)
		else
		begin
			$display("string_mix went silent after damping only one of two strings");
			errors++;
		end
		damp_and_check(note_b);
		finish_test("voice independence");

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired before the tests completed");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- files.f
design/string_pkg.sv
design/note_decoder.sv
design/noise_bank.sv
design/string_voice.sv
design/string_bank.sv
design/string_synth_top.sv
bench/tb_string_synth.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_string_synth
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
